/* Bender.yml */
package:
  name: fpsu

sources:
  - files:
      - design/fpsu_pkg.sv
      - design/operand_bypass.sv
      - design/fpsu_decode.sv
      - design/fadd_lane.sv
      - design/fexcpt_merge.sv
      - design/wb_arbiter.sv
      - design/fpsu_top.sv
  - target: test
    files:
      - test/fpsu_tb.sv

/* design/fadd_lane.sv */
// single-precision add lane
`timescale 1ns/1ns

module fadd_lane import fpsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid_in,
  input  lane_ctl_t ctl,
  input  sgl_t      a,
  input  sgl_t      b,
  output logic      valid_out,
  output sgl_t      res,
  output fp_flags_t flg
);

  sgl_t               x;
  sgl_t               y;
  logic               sx;
  logic               sy;
  logic [EXP_W-1:0]   ex;
  logic [EXP_W-1:0]   ey;
  logic [FRAC_W-1:0]  fx;
  logic [FRAC_W-1:0]  fy;
  logic               x_nan;
  logic               y_nan;
  logic               x_inf;
  logic               y_inf;
  logic               swap;
  logic [EXP_W-1:0]   e_big;
  logic [EXP_W-1:0]   e_sml;
  logic [FRAC_W:0]    m_big;
  logic [FRAC_W:0]    m_sml;
  logic [EXP_W-1:0]   diff;
  logic [4:0]         sh_amt;
  logic [FRAC_W+32:0] wide;
  logic [FRAC_W+3:0]  aln;
  sgl_t               lres;
  logic               fixed;
  sgl_t               fix_res;
  fp_flags_t          fix_flg;

  logic               s1_valid;
  logic               s1_fixed;
  sgl_t               s1_fix_res;
  fp_flags_t          s1_fix_flg;
  logic               s1_sign;
  logic               s1_sub;
  logic [EXP_W-1:0]   s1_exp;
  logic [FRAC_W:0]    s1_mant;
  logic [FRAC_W+3:0]  s1_aln;

  logic [FRAC_W+4:0]  sum;
  logic [FRAC_W+3:0]  norm;
  logic [4:0]         lz;
  logic [EXP_W+1:0]   exp_n;
  logic [FRAC_W:0]    mant_n;
  logic               drop;
  sgl_t               res_nxt;
  fp_flags_t          flg_nxt;
  int                 i;

  // stage 1: flush, swap, align
  always_comb begin
    x  = ctl.is_rsub ? b : a;
    y  = ctl.is_rsub ? a : b;
    sx = x[SGL_W-1];
    sy = y[SGL_W-1] ^ ctl.is_sub;
    ex = x[SGL_W-2 -: EXP_W];
    ey = y[SGL_W-2 -: EXP_W];
    // denormals read as zero
    fx = (ex == '0) ? '0 : x[FRAC_W-1:0];
    fy = (ey == '0) ? '0 : y[FRAC_W-1:0];
    x_nan = (ex == EXP_INF) && (fx != '0);
    y_nan = (ey == EXP_INF) && (fy != '0);
    x_inf = (ex == EXP_INF) && (fx == '0);
    y_inf = (ey == EXP_INF) && (fy == '0);

    swap   = {ey, fy} > {ex, fx};
    e_big  = swap ? ey : ex;
    e_sml  = swap ? ex : ey;
    m_big  = {e_big != '0, swap ? fy : fx};
    m_sml  = {e_sml != '0, swap ? fx : fy};
    diff   = e_big - e_sml;
    sh_amt = (diff > 8'd31) ? 5'd31 : diff[4:0];
    wide   = {m_sml, 32'b0} >> sh_amt;
    // mantissa, guard, round, then sticky
    aln    = {wide[FRAC_W+32 -: FRAC_W+3], |wide[29:0]};

    case (ctl.logic_sel)
      2'd0:    lres = a & b;
      2'd1:    lres = a | b;
      2'd2:    lres = a ^ b;
      default: lres = a & ~b;
    endcase

    fixed   = 1'b1;
    fix_flg = '0;
    if (ctl.logic_en) begin
      fix_res = lres;
    end else if (x_nan || y_nan || (x_inf && y_inf && (sx != sy))) begin
      fix_res         = CANON_NAN;
      fix_flg.invalid = 1'b1;
    end else if (x_inf) begin
      fix_res = {sx, EXP_INF, {FRAC_W{1'b0}}};
    end else if (y_inf) begin
      fix_res = {sy, EXP_INF, {FRAC_W{1'b0}}};
    end else begin
      fixed   = 1'b0;
      fix_res = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= valid_in;
    end
  end

  always_ff @(posedge clk) begin
    s1_fixed   <= fixed;
    s1_fix_res <= fix_res;
    s1_fix_flg <= fix_flg;
    s1_sign    <= swap ? sy : sx;
    s1_sub     <= sx ^ sy;
    s1_exp     <= e_big;
    s1_mant    <= m_big;
    s1_aln     <= aln;
  end

  // stage 2: add, normalize, truncate
  always_comb begin
    if (s1_sub) begin
      sum = {1'b0, s1_mant, 3'b0} - {1'b0, s1_aln};
    end else begin
      sum = {1'b0, s1_mant, 3'b0} + {1'b0, s1_aln};
    end

    // highest set bit wins
    lz = '0;
    for (i = 0; i <= FRAC_W + 3; i++) begin
      if (sum[i]) begin
        lz = 5'(FRAC_W + 3 - i);
      end
    end
    norm = sum[FRAC_W+3:0] << lz;

    if (sum[FRAC_W+4]) begin
      mant_n = sum[FRAC_W+4:4];
      drop   = |sum[3:0];
      exp_n  = {2'b0, s1_exp} + 10'd1;
    end else begin
      mant_n = norm[FRAC_W+3:3];
      drop   = |norm[2:0];
      exp_n  = {2'b0, s1_exp} - {5'b0, lz};
    end

    flg_nxt = '0;
    if (s1_fixed) begin
      res_nxt = s1_fix_res;
      flg_nxt = s1_fix_flg;
    end else if (sum == '0) begin
      // cancellation gives +0, two like zeros keep their sign
      res_nxt = {~s1_sub & s1_sign, {(SGL_W-1){1'b0}}};
    end else if (exp_n[EXP_W+1] || exp_n == '0) begin
      res_nxt = {s1_sign, {(SGL_W-1){1'b0}}};
    end else if (exp_n > {2'b0, EXP_MAXF}) begin
      res_nxt          = {s1_sign, EXP_MAXF, {FRAC_W{1'b1}}};
      flg_nxt.overflow = 1'b1;
      flg_nxt.inexact  = 1'b1;
    end else begin
      res_nxt         = {s1_sign, exp_n[EXP_W-1:0], mant_n[FRAC_W-1:0]};
      flg_nxt.inexact = drop;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_nxt;
    flg <= flg_nxt;
  end

endmodule

/* design/fexcpt_merge.sv */
// exception merge and retire code
`timescale 1ns/1ns

module fexcpt_merge import fpsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      valid_in,
  input  fp_flags_t flg_hi,
  input  fp_flags_t flg_lo,
  input  fp_flags_t trap_en,
  output logic      ret_valid,
  output ret_code_t ret_code,
  output fp_flags_t flags
);

  fp_flags_t raised;
  fp_flags_t masked;
  ret_code_t code;

  always_comb begin
    raised = flg_hi | flg_lo;
    masked = raised & trap_en;
    // invalid outranks overflow, overflow outranks inexact
    if (masked.invalid) begin
      code = RET_INVALID;
    end else if (masked.overflow) begin
      code = RET_OVERFLOW;
    end else if (masked.inexact) begin
      code = RET_INEXACT;
    end else begin
      code = RET_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid <= 1'b0;
      ret_code  <= RET_NONE;
      flags     <= '0;
    end else begin
      ret_valid <= valid_in && (masked != '0);
      if (valid_in) begin
        ret_code <= code;
        flags    <= raised;
      end
    end
  end

endmodule

/* design/fpsu_decode.sv */
// opcode decode to lane control
`timescale 1ns/1ns

module fpsu_decode import fpsu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      en,
  input  fpsu_op_e  op,
  output lane_ctl_t ctl,
  output logic      valid
);

  lane_ctl_t ctl_nxt;

  always_comb begin
    ctl_nxt = '0;
    case (op)
      OP_SUB: begin
        ctl_nxt.is_sub = 1'b1;
      end
      OP_RSUB: begin
        // b - a, operands swapped in the lane
        ctl_nxt.is_sub  = 1'b1;
        ctl_nxt.is_rsub = 1'b1;
      end
      OP_AND: begin
        ctl_nxt.logic_en  = 1'b1;
        ctl_nxt.logic_sel = 2'd0;
      end
      OP_OR: begin
        ctl_nxt.logic_en  = 1'b1;
        ctl_nxt.logic_sel = 2'd1;
      end
      OP_XOR: begin
        ctl_nxt.logic_en  = 1'b1;
        ctl_nxt.logic_sel = 2'd2;
      end
      OP_ANDN: begin
        ctl_nxt.logic_en  = 1'b1;
        ctl_nxt.logic_sel = 2'd3;
      end
      default: begin
        ctl_nxt = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      ctl   <= '0;
    end else begin
      valid <= en;
      if (en) begin
        ctl <= ctl_nxt;
      end
    end
  end

endmodule

/* design/fpsu_pkg.sv */
// packed single add unit definitions

package fpsu_pkg;

  localparam int DATA_W   = 64;
  localparam int SGL_W    = 32;
  localparam int EXP_W    = 8;
  localparam int FRAC_W   = 23;
  localparam int EXP_BIAS = 127;
  localparam int NUM_BYP  = 4;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SGL_W-1:0]  sgl_t;
  typedef logic [2:0]        fwd_sel_t;
  typedef logic [1:0]        ret_code_t;

  // all forwarding buses side by side, bus 0 in the low word
  typedef data_t [NUM_BYP-1:0] byp_t;

  // quiet nan, sign clear
  localparam sgl_t CANON_NAN = 32'h7fc0_0000;

  // biased exponents of inf/nan and of the largest finite value
  localparam logic [EXP_W-1:0] EXP_INF  = '1;
  localparam logic [EXP_W-1:0] EXP_MAXF = EXP_W'(2 * EXP_BIAS);

  localparam ret_code_t RET_NONE     = 2'd0;
  localparam ret_code_t RET_INVALID  = 2'd1;
  localparam ret_code_t RET_OVERFLOW = 2'd2;
  localparam ret_code_t RET_INEXACT  = 2'd3;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_RSUB = 3'd2,
    OP_AND  = 3'd3,
    OP_OR   = 3'd4,
    OP_XOR  = 3'd5,
    OP_ANDN = 3'd6
  } fpsu_op_e;

  // logic_sel: 0 and, 1 or, 2 xor, 3 a and not b
  typedef struct packed {
    logic       is_sub;
    logic       is_rsub;
    logic       logic_en;
    logic [1:0] logic_sel;
  } lane_ctl_t;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
  } fp_flags_t;

  typedef enum logic [1:0] {
    SRC_UNIT = 2'd0,
    SRC_ALT0 = 2'd1,
    SRC_ALT1 = 2'd2
  } wb_src_e;

  typedef struct packed {
    wb_src_e src;
    logic    parity;
    data_t   data;
  } wb_word_t;

endpackage

/* design/fpsu_top.sv */
// packed single add unit top
`timescale 1ns/1ns

module fpsu_top import fpsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       en,
  input  fpsu_op_e   op,
  input  data_t      a,
  input  data_t      b,
  input  fwd_sel_t   fwd_a,
  input  fwd_sel_t   fwd_b,
  input  logic       late_a,
  input  logic       late_b,
  input  byp_t       byp,
  input  logic [1:0] alt_req,
  input  data_t      alt_data0,
  input  data_t      alt_data1,
  input  fp_flags_t  trap_en,
  output logic       wb_valid,
  output wb_word_t   wb,
  output logic [1:0] alt_gnt,
  output logic       ret_valid,
  output ret_code_t  ret_code,
  output fp_flags_t  flags
);

  data_t     opnd_a;
  data_t     opnd_b;
  lane_ctl_t ctl;
  logic      op_valid;
  logic      vld_hi;
  logic      vld_lo;
  sgl_t      res_hi;
  sgl_t      res_lo;
  fp_flags_t flg_hi;
  fp_flags_t flg_lo;

  operand_bypass u_byp_a (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .direct (a),
    .fwd    (fwd_a),
    .late   (late_a),
    .byp    (byp),
    .opnd   (opnd_a)
  );

  operand_bypass u_byp_b (
    .clk    (clk),
    .rst    (rst),
    .en     (en),
    .direct (b),
    .fwd    (fwd_b),
    .late   (late_b),
    .byp    (byp),
    .opnd   (opnd_b)
  );

  fpsu_decode u_decode (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .op    (op),
    .ctl   (ctl),
    .valid (op_valid)
  );

  fadd_lane u_lane_hi (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (op_valid),
    .ctl       (ctl),
    .a         (opnd_a[DATA_W-1:SGL_W]),
    .b         (opnd_b[DATA_W-1:SGL_W]),
    .valid_out (vld_hi),
    .res       (res_hi),
    .flg       (flg_hi)
  );

  fadd_lane u_lane_lo (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (op_valid),
    .ctl       (ctl),
    .a         (opnd_a[SGL_W-1:0]),
    .b         (opnd_b[SGL_W-1:0]),
    .valid_out (vld_lo),
    .res       (res_lo),
    .flg       (flg_lo)
  );

  // both lanes run in lockstep, either valid marks the pair
  fexcpt_merge u_excpt (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (vld_lo),
    .flg_hi    (flg_hi),
    .flg_lo    (flg_lo),
    .trap_en   (trap_en),
    .ret_valid (ret_valid),
    .ret_code  (ret_code),
    .flags     (flags)
  );

  wb_arbiter u_arb (
    .clk        (clk),
    .rst        (rst),
    .unit_valid (vld_hi),
    .unit_data  ({res_hi, res_lo}),
    .alt_req    (alt_req),
    .alt_data0  (alt_data0),
    .alt_data1  (alt_data1),
    .alt_gnt    (alt_gnt),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

endmodule

/* design/operand_bypass.sv */
// operand capture with bus forwarding
`timescale 1ns/1ns

module operand_bypass import fpsu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  input  data_t    direct,
  input  fwd_sel_t fwd,
  input  logic     late,
  input  byp_t     byp,
  output data_t    opnd
);

  byp_t     byp_q;
  fwd_sel_t idx;
  data_t    cur_word;
  data_t    held_word;
  data_t    pick;

  // bus words as seen one edge earlier
  always_ff @(posedge clk) begin
    byp_q <= byp;
  end

  always_comb begin
    idx       = fwd - fwd_sel_t'(1);
    cur_word  = byp[idx[1:0]];
    held_word = byp_q[idx[1:0]];
    // codes above the bus count fall back to the direct input
    if (fwd == '0 || fwd > fwd_sel_t'(NUM_BYP)) begin
      pick = direct;
    end else if (late) begin
      pick = held_word;
    end else begin
      pick = cur_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      opnd <= '0;
    end else if (en) begin
      opnd <= pick;
    end
  end

endmodule

/* design/wb_arbiter.sv */
// write-back bus arbiter
`timescale 1ns/1ns

module wb_arbiter import fpsu_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       unit_valid,
  input  data_t      unit_data,
  input  logic [1:0] alt_req,
  input  data_t      alt_data0,
  input  data_t      alt_data1,
  output logic [1:0] alt_gnt,
  output logic       wb_valid,
  output wb_word_t   wb
);

  wb_src_e nxt_src;
  data_t   nxt_data;
  logic    nxt_valid;

  // unit first, then alt0, then alt1
  always_comb begin
    alt_gnt  = 2'b00;
    nxt_src  = SRC_UNIT;
    nxt_data = unit_data;
    if (!unit_valid) begin
      if (alt_req[0]) begin
        alt_gnt[0] = 1'b1;
        nxt_src    = SRC_ALT0;
        nxt_data   = alt_data0;
      end else if (alt_req[1]) begin
        alt_gnt[1] = 1'b1;
        nxt_src    = SRC_ALT1;
        nxt_data   = alt_data1;
      end
    end
    nxt_valid = unit_valid | (|alt_req);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= nxt_valid;
    end
  end

  always_ff @(posedge clk) begin
    wb.src    <= nxt_src;
    wb.parity <= ^nxt_data;
    wb.data   <= nxt_data;
  end

endmodule

/* sources.f */
design/fpsu_pkg.sv
design/operand_bypass.sv
design/fpsu_decode.sv
design/fadd_lane.sv
design/fexcpt_merge.sv
design/wb_arbiter.sv
design/fpsu_top.sv
test/fpsu_tb.sv

/* test/fpsu_tb.sv */
// packed single add unit testbench
`timescale 1ns/1ns

module fpsu_tb import fpsu_pkg::*; ();

  localparam int MAX_CYCLES = 4000;
  localparam int NUM_ALT    = 24;

  typedef struct packed {
    sgl_t      res;
    fp_flags_t flg;
  } lane_res_t;

  typedef struct packed {
    data_t       data;
    fp_flags_t   flg;
    logic        ret_v;
    ret_code_t   code;
    logic [31:0] due;
  } expect_t;

  typedef struct packed {
    wb_src_e src;
    data_t   data;
  } alt_word_t;

  logic       clk;
  logic       rst;
  logic       en;
  fpsu_op_e   op;
  data_t      a;
  data_t      b;
  fwd_sel_t   fwd_a;
  fwd_sel_t   fwd_b;
  logic       late_a;
  logic       late_b;
  byp_t       byp;
  data_t      bus_drv [1:3];
  logic [1:0] alt_req;
  data_t      alt_data0;
  data_t      alt_data1;
  fp_flags_t  trap_en;
  logic       wb_valid;
  wb_word_t   wb;
  logic [1:0] alt_gnt;
  logic       ret_valid;
  ret_code_t  ret_code;
  fp_flags_t  flags;

  expect_t     exp_q [$];
  alt_word_t   alt_q [$];
  byp_t        byp_last;
  byp_t        byp_held;
  int unsigned cyc;
  int          errors;
  int          err_mark;
  int          tests_pass;
  int          tests_fail;

  sgl_t special_val [12] = '{
    32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0001, 32'hff80_0001,
    32'h0000_0123, 32'h8040_0000, 32'h7f7f_ffff, 32'hff7f_ffff,
    32'h0000_0000, 32'h8000_0000, 32'h3f80_0000, 32'h0080_0001
  };
  fp_flags_t trap_pat [6] = '{3'b000, 3'b100, 3'b010, 3'b001, 3'b111, 3'b011};

  // bus 0 carries the write-back word back in
  assign byp = {bus_drv[3], bus_drv[2], bus_drv[1], wb.data};

  fpsu_top u_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles, %0d unit results still outstanding",
               cyc, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic sgl_t rand_normal();
    sgl_t v;
    v[31]    = $urandom % 2;
    v[30:23] = 8'(110 + $urandom % 36);
    v[22:0]  = 23'($urandom);
    return v;
  endfunction

  function automatic sgl_t pick_special();
    return special_val[$urandom % 12];
  endfunction

  // exact sum, then truncate toward zero
  function automatic lane_res_t ref_fadd(input fpsu_op_e fop, input sgl_t va, input sgl_t vb);
    lane_res_t    r;
    sgl_t         x;
    sgl_t         y;
    logic         sx;
    logic         sy;
    logic         neg;
    int           ex;
    int           ey;
    int           emin;
    int           p;
    int           e_res;
    logic [23:0]  mx;
    logic [23:0]  my;
    logic [300:0] vx;
    logic [300:0] vy;
    logic [300:0] mag;
    logic [300:0] tmp;
    r  = '0;
    x  = (fop == OP_RSUB) ? vb : va;
    y  = (fop == OP_RSUB) ? va : vb;
    sx = x[31];
    sy = y[31] ^ (fop != OP_ADD);
    ex = x[30:23];
    ey = y[30:23];
    if ((ex == 255 && x[22:0] != 0) || (ey == 255 && y[22:0] != 0) ||
        (ex == 255 && ey == 255 && sx != sy)) begin
      r.res         = CANON_NAN;
      r.flg.invalid = 1'b1;
      return r;
    end
    if (ex == 255) begin
      r.res = {sx, 8'hff, 23'h0};
      return r;
    end
    if (ey == 255) begin
      r.res = {sy, 8'hff, 23'h0};
      return r;
    end
    // denormals count as zero
    mx = (ex == 0) ? 24'h0 : {1'b1, x[22:0]};
    my = (ey == 0) ? 24'h0 : {1'b1, y[22:0]};
    if (mx == 0 && my == 0) begin
      r.res = {sx & sy, 31'h0};
      return r;
    end
    if (mx == 0) begin
      r.res = {sy, y[30:0]};
      return r;
    end
    if (my == 0) begin
      r.res = {sx, x[30:0]};
      return r;
    end
    emin = (ex < ey) ? ex : ey;
    vx = '0;
    vy = '0;
    vx[23:0] = mx;
    vy[23:0] = my;
    vx = vx << (ex - emin);
    vy = vy << (ey - emin);
    if (sx == sy) begin
      mag = vx + vy;
      neg = sx;
    end else if (vx >= vy) begin
      mag = vx - vy;
      neg = sx;
    end else begin
      mag = vy - vx;
      neg = sy;
    end
    if (mag == 0) begin
      return r;
    end
    p = 0;
    for (int i = 0; i < 301; i++) begin
      if (mag[i]) begin
        p = i;
      end
    end
    e_res = p + emin - 23;
    if (e_res >= 255) begin
      r.res          = {neg, 8'hfe, 23'h7f_ffff};
      r.flg.overflow = 1'b1;
      r.flg.inexact  = 1'b1;
    end else if (e_res <= 0) begin
      r.res = {neg, 31'h0};
    end else if (p >= 23) begin
      tmp           = mag >> (p - 23);
      r.flg.inexact = (tmp << (p - 23)) != mag;
      r.res         = {neg, 8'(e_res), tmp[22:0]};
    end else begin
      tmp   = mag << (23 - p);
      r.res = {neg, 8'(e_res), tmp[22:0]};
    end
    return r;
  endfunction

  function automatic data_t ref_logic(input fpsu_op_e fop, input data_t va, input data_t vb);
    case (fop)
      OP_AND:  return va & vb;
      OP_OR:   return va | vb;
      OP_XOR:  return va ^ vb;
      default: return va & ~vb;
    endcase
  endfunction

  function automatic expect_t make_expect(input fpsu_op_e fop, input data_t va, input data_t vb);
    expect_t   e;
    lane_res_t hi;
    lane_res_t lo;
    fp_flags_t m;
    if (fop == OP_ADD || fop == OP_SUB || fop == OP_RSUB) begin
      hi     = ref_fadd(fop, va[63:32], vb[63:32]);
      lo     = ref_fadd(fop, va[31:0], vb[31:0]);
      e.data = {hi.res, lo.res};
      e.flg  = hi.flg | lo.flg;
    end else begin
      e.data = ref_logic(fop, va, vb);
      e.flg  = '0;
    end
    m       = e.flg & trap_en;
    e.ret_v = (m != '0);
    if (m.invalid) begin
      e.code = RET_INVALID;
    end else if (m.overflow) begin
      e.code = RET_OVERFLOW;
    end else if (m.inexact) begin
      e.code = RET_INEXACT;
    end else begin
      e.code = RET_NONE;
    end
    // capture edge plus three pipeline edges
    e.due = cyc + 4;
    return e;
  endfunction

  function automatic data_t pick_opnd(input fwd_sel_t f, input logic held, input data_t direct);
    if (f == 0 || f > 4) begin
      return direct;
    end
    return held ? byp_held[f - 1] : byp_last[f - 1];
  endfunction

  task automatic next_cycle();
    int k;
    @(negedge clk);
    byp_held = byp_last;
    en       = 1'b0;
    for (k = 1; k <= 3; k++) begin
      bus_drv[k] = {rand_normal(), rand_normal()};
    end
    byp_last = {bus_drv[3], bus_drv[2], bus_drv[1], wb.data};
  endtask

  task automatic issue(input fpsu_op_e fop, input data_t va, input data_t vb,
                       input fwd_sel_t fa, input fwd_sel_t fb, input logic la, input logic lb);
    next_cycle();
    en     = 1'b1;
    op     = fop;
    a      = va;
    b      = vb;
    fwd_a  = fa;
    fwd_b  = fb;
    late_a = la;
    late_b = lb;
    exp_q.push_back(make_expect(fop, pick_opnd(fa, la, va), pick_opnd(fb, lb, vb)));
  endtask

  task automatic issue_direct(input fpsu_op_e fop, input data_t va, input data_t vb);
    issue(fop, va, vb, 3'd0, 3'd0, 1'b0, 1'b0);
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || alt_q.size() != 0) begin
      next_cycle();
    end
    repeat (2) next_cycle();
  endtask

  task automatic end_test(input string name);
    drain();
    if (errors == err_mark) begin
      tests_pass++;
      $display("%s: pass", name);
    end else begin
      tests_fail++;
      $display("%s: fail, %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  task automatic check_unit(input expect_t e);
    assert (wb.data === e.data) else begin
      $display("Mismatch at %0t: data %h, expected %h", $time, wb.data, e.data);
      errors++;
    end
    assert (flags === e.flg) else begin
      $display("Mismatch at %0t: flags %b, expected %b", $time, flags, e.flg);
      errors++;
    end
    assert (ret_valid === e.ret_v && ret_code === e.code) else begin
      $display("Mismatch at %0t: retire %b/%0d, expected %b/%0d", $time,
               ret_valid, ret_code, e.ret_v, e.code);
      errors++;
    end
    assert (cyc == e.due) else begin
      $display("error at %0t: result arrived in cycle %0d instead of cycle %0d",
               $time, cyc, e.due);
      errors++;
    end
  endtask

  // scoreboard on the write-back bus
  always @(negedge clk) begin
    alt_word_t w;
    if (rst === 1'b0) begin
      if (wb_valid === 1'b1) begin
        assert (wb.parity === ^wb.data) else begin
          $display("Mismatch at %0t: parity %b for data %h", $time, wb.parity, wb.data);
          errors++;
        end
      end
      if (wb_valid === 1'b1 && wb.src == SRC_UNIT) begin
        assert (exp_q.size() != 0) else begin
          $display("error at %0t: unit result on the bus with none outstanding", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          check_unit(exp_q.pop_front());
        end
      end else begin
        if (wb_valid === 1'b1) begin
          assert (alt_q.size() != 0) else begin
            $display("error at %0t: alternate word on the bus that was never granted", $time);
            errors++;
          end
          if (alt_q.size() != 0) begin
            w = alt_q.pop_front();
            assert (wb.src == w.src && wb.data === w.data) else begin
              $display("Mismatch at %0t: bus %0d/%h, expected %0d/%h", $time,
                       wb.src, wb.data, w.src, w.data);
              errors++;
            end
          end
        end
        assert (ret_valid === 1'b0) else begin
          $display("error at %0t: retire valid without a unit result", $time);
          errors++;
        end
      end
    end
  end

  task automatic drive_alt();
    int         sent [2];
    int         k;
    logic [1:0] gnt_seen;
    alt_word_t  w;
    sent[0]  = 0;
    sent[1]  = 0;
    gnt_seen = 2'b00;
    while (sent[0] < NUM_ALT || sent[1] < NUM_ALT) begin
      @(negedge clk);
      // grant seen before the last edge means that edge took the word
      for (k = 0; k < 2; k++) begin
        if (gnt_seen[k]) begin
          sent[k]++;
          alt_req[k] = 1'b0;
        end
      end
      if (!alt_req[0] && sent[0] < NUM_ALT && $urandom % 2 == 1) begin
        alt_req[0] = 1'b1;
        alt_data0  = {$urandom, $urandom};
      end
      if (!alt_req[1] && sent[1] < NUM_ALT && $urandom % 2 == 1) begin
        alt_req[1] = 1'b1;
        alt_data1  = {$urandom, $urandom};
      end
      #2;
      gnt_seen = alt_gnt;
      assert ((gnt_seen & ~alt_req) == 2'b00 && gnt_seen != 2'b11) else begin
        $display("error at %0t: grant %b does not fit requests %b", $time, gnt_seen, alt_req);
        errors++;
      end
      assert (!(alt_req == 2'b11 && gnt_seen[1])) else begin
        $display("error at %0t: alternate 1 granted while alternate 0 waits", $time);
        errors++;
      end
      if (gnt_seen[0]) begin
        w.src  = SRC_ALT0;
        w.data = alt_data0;
        alt_q.push_back(w);
      end
      if (gnt_seen[1]) begin
        w.src  = SRC_ALT1;
        w.data = alt_data1;
        alt_q.push_back(w);
      end
    end
  endtask

  initial begin
    int i;
    int t;
    void'($urandom(27));
    clk        = 1'b0;
    rst        = 1'b1;
    en         = 1'b0;
    op         = OP_ADD;
    a          = '0;
    b          = '0;
    fwd_a      = '0;
    fwd_b      = '0;
    late_a     = 1'b0;
    late_b     = 1'b0;
    bus_drv[1] = '0;
    bus_drv[2] = '0;
    bus_drv[3] = '0;
    alt_req    = 2'b00;
    alt_data0  = '0;
    alt_data1  = '0;
    trap_en    = '0;
    byp_last   = '0;
    byp_held   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    trap_en = 3'b111;
    for (i = 0; i < 200; i++) begin
      if ($urandom % 4 == 0) begin
        next_cycle();
      end
      issue_direct(fpsu_op_e'($urandom % 3), {rand_normal(), rand_normal()},
                   {rand_normal(), rand_normal()});
    end
    end_test("packed add, sub, rsub");

    for (t = 0; t < 6; t++) begin
      drain();
      trap_en = trap_pat[t];
      // overflow with saturation, cancellation and underflow, inf minus inf
      issue_direct(OP_ADD, {32'h7f7f_ffff, 32'h7f7f_ffff}, {32'h7f7f_ffff, 32'h3f80_0000});
      issue_direct(OP_SUB, {32'h3fc0_0000, 32'h0080_0001}, {32'h3fc0_0000, 32'h0080_0000});
      issue_direct(OP_ADD, {32'h7f80_0000, 32'h0000_0123}, {32'hff80_0000, 32'h3f80_0000});
      for (i = 0; i < 16; i++) begin
        issue_direct(fpsu_op_e'($urandom % 3), {pick_special(), pick_special()},
                     {pick_special(), pick_special()});
      end
    end
    end_test("special values and traps");

    trap_en = 3'b111;
    for (i = 0; i < 100; i++) begin
      issue_direct(fpsu_op_e'(3 + $urandom % 4), {$urandom, $urandom}, {$urandom, $urandom});
    end
    end_test("logic ops");

    for (i = 0; i < 120; i++) begin
      issue(fpsu_op_e'($urandom % 7), {rand_normal(), rand_normal()},
            {rand_normal(), rand_normal()}, fwd_sel_t'($urandom % 5),
            fwd_sel_t'($urandom % 5), $urandom % 2, $urandom % 2);
    end
    end_test("forwarding");

    for (i = 0; i < 64; i++) begin
      issue_direct(fpsu_op_e'($urandom % 7), {rand_normal(), rand_normal()},
                   {rand_normal(), rand_normal()});
    end
    end_test("back-to-back issue");

    fork
      begin
        for (i = 0; i < 80; i++) begin
          if ($urandom % 3 == 0) begin
            next_cycle();
          end
          issue_direct(fpsu_op_e'($urandom % 7), {rand_normal(), rand_normal()},
                       {rand_normal(), rand_normal()});
        end
        // drop en after the last issue
        next_cycle();
      end
      drive_alt();
    join
    end_test("alternate sources");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
